// File: vlog.f
verilog/wb_pkg.sv
verilog/wb_candidate_if.sv
verilog/wb_candidate_search.sv
verilog/wb_grant_select.sv
verilog/wb_result_format.sv
verilog/write_back_arbiter.sv
test/tb_write_back_arbiter.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation output

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_write_back_arbiter -f vlog.f -o tb_sim || exit 1

sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST PASSED" && exit 0 || exit 1

// File: test/tb_write_back_arbiter.sv
/* Write-back arbiter testbench
   Directed tests of round-robin grants, SPR sharing and the XER/CR0 side writes */

`timescale 1ns/10ps

module tb_write_back_arbiter;

    localparam int RESET_CYCLES = 10;
    // Three resets plus roughly 40 cycles of traffic, four times over
    localparam int MAX_CYCLES = 4 * (3 * RESET_CYCLES + 40);

    logic clk;
    logic rst;
    logic gpr_valid [0:wb_pkg::NUM_SOURCES-1];
    logic gpr_ready [0:wb_pkg::NUM_SOURCES-1];
    logic [0:wb_pkg::RS_ID_W-1] gpr_rs_id [0:wb_pkg::NUM_SOURCES-1];
    logic [0:wb_pkg::GPR_ADDR_W-1] gpr_addr [0:wb_pkg::NUM_SOURCES-1];
    logic [0:wb_pkg::DATA_W-1] gpr_data [0:wb_pkg::NUM_SOURCES-1];
    wb_pkg::cond_exception_t gpr_flags [0:wb_pkg::NUM_SOURCES-1];
    logic spr_valid;
    logic spr_ready;
    logic [0:wb_pkg::RS_ID_W-1] spr_rs_id;
    logic [0:wb_pkg::SPR_ADDR_W-1] spr_addr;
    logic [0:wb_pkg::DATA_W-1] spr_data;
    logic gpr_wr_valid;
    logic [0:wb_pkg::RS_ID_W-1] gpr_wr_rs_id;
    logic [0:wb_pkg::GPR_ADDR_W-1] gpr_wr_addr;
    logic [0:wb_pkg::DATA_W-1] gpr_wr_data;
    logic spr_wr_valid;
    logic [0:wb_pkg::RS_ID_W-1] spr_wr_rs_id;
    logic [0:wb_pkg::SPR_ADDR_W-1] spr_wr_addr;
    logic [0:wb_pkg::DATA_W-1] spr_wr_data;
    logic cr0_wr_valid;
    logic [0:wb_pkg::RS_ID_W-1] cr0_wr_rs_id;
    wb_pkg::cr_field_t cr0_wr_value;

    int errors;
    int checks;
    int cycle_count;
    int seed;

    write_back_arbiter i_write_back_arbiter (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %h, got %h at %0t", name, expected, got, $time);
        end
    endtask

    function automatic wb_pkg::cond_exception_t make_flags(input logic xer_valid,
            input logic [31:0] xer, input logic cr0_valid, input logic so);
        wb_pkg::cond_exception_t flags;
        flags.xer_valid = xer_valid;
        flags.xer = xer;
        flags.cr0_valid = cr0_valid;
        flags.so = so;
        return flags;
    endfunction

    function automatic logic any_gpr_ready();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < wb_pkg::NUM_SOURCES; i++) begin
            seen = seen | gpr_ready[i];
        end
        return seen;
    endfunction

    task automatic clear_inputs();
        for (int i = 0; i < wb_pkg::NUM_SOURCES; i++) begin
            gpr_valid[i] <= 1'b0;
            gpr_rs_id[i] <= '0;
            gpr_addr[i] <= '0;
            gpr_data[i] <= '0;
            gpr_flags[i] <= '0;
        end
        spr_valid <= 1'b0;
        spr_rs_id <= '0;
        spr_addr <= '0;
        spr_data <= '0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
    endtask

    task automatic offer_gpr(input int idx, input logic [4:0] tag, input logic [4:0] addr,
                             input logic [31:0] data, input wb_pkg::cond_exception_t flags);
        gpr_valid[idx] <= 1'b1;
        gpr_rs_id[idx] <= tag;
        gpr_addr[idx] <= addr;
        gpr_data[idx] <= data;
        gpr_flags[idx] <= flags;
    endtask

    task automatic offer_spr(input logic [4:0] tag, input logic [9:0] addr,
                             input logic [31:0] data);
        spr_valid <= 1'b1;
        spr_rs_id <= tag;
        spr_addr <= addr;
        spr_data <= data;
    endtask

    // Called on a falling edge, returns on the falling edge where ready is seen
    task automatic wait_gpr_ready(input int idx);
        while (gpr_ready[idx] !== 1'b1) @(negedge clk);
    endtask

    task automatic wait_spr_ready();
        while (spr_ready !== 1'b1) @(negedge clk);
    endtask

    task automatic check_gpr_write(input logic [4:0] tag, input logic [4:0] addr,
                                   input logic [31:0] data);
        check_hex("gpr_wr_valid", 32'(gpr_wr_valid), 32'd1);
        check_hex("gpr_wr_rs_id", 32'(gpr_wr_rs_id), 32'(tag));
        check_hex("gpr_wr_addr", 32'(gpr_wr_addr), 32'(addr));
        check_hex("gpr_wr_data", 32'(gpr_wr_data), data);
    endtask

    task automatic check_spr_write(input logic [4:0] tag, input logic [9:0] addr,
                                   input logic [31:0] data);
        check_hex("spr_wr_valid", 32'(spr_wr_valid), 32'd1);
        check_hex("spr_wr_rs_id", 32'(spr_wr_rs_id), 32'(tag));
        check_hex("spr_wr_addr", 32'(spr_wr_addr), 32'(addr));
        check_hex("spr_wr_data", 32'(spr_wr_data), data);
    endtask

    task automatic idle_after_reset();
        apply_reset();
        check_hex("gpr_wr_valid", 32'(gpr_wr_valid), 32'd0);
        check_hex("spr_wr_valid", 32'(spr_wr_valid), 32'd0);
        check_hex("cr0_wr_valid", 32'(cr0_wr_valid), 32'd0);
        check_hex("spr_ready", 32'(spr_ready), 32'd0);
        for (int i = 0; i < wb_pkg::NUM_SOURCES; i++) begin
            check_hex($sformatf("gpr_ready[%0d]", i), 32'(gpr_ready[i]), 32'd0);
        end
    endtask

    task automatic single_gpr_side_writes();
        logic [31:0] results [0:2];
        logic [3:0] cr0_expect [0:2];
        logic so_flag [0:2];
        logic [31:0] xer_val;
        logic [4:0] tag;
        results = '{32'h8000_0010, 32'h0000_1234, 32'h0000_0000};
        // lt gt eq so, negative then positive then zero
        cr0_expect = '{4'b1001, 4'b0100, 4'b0011};
        so_flag = '{1'b1, 1'b0, 1'b1};
        for (int k = 0; k < 3; k++) begin
            tag = 5'(3 + k);
            xer_val = 32'hA5A5_0000 + 32'(k);
            @(posedge clk);
            offer_gpr(2, tag, 5'd7, results[k], make_flags(1'b1, xer_val, 1'b1, so_flag[k]));
            @(negedge clk);
            wait_gpr_ready(2);
            @(posedge clk);
            gpr_valid[2] <= 1'b0;
            @(negedge clk);
            check_gpr_write(tag, 5'd7, results[k]);
            // XER lands at SPR address 1 with the GPR tag
            check_spr_write(tag, 10'd1, xer_val);
            check_hex("cr0_wr_valid", 32'(cr0_wr_valid), 32'd1);
            check_hex("cr0_wr_rs_id", 32'(cr0_wr_rs_id), 32'(tag));
            check_hex("cr0_wr_value", 32'(cr0_wr_value), 32'(cr0_expect[k]));
        end
    endtask

    task automatic round_robin_order();
        int src;
        apply_reset();
        @(posedge clk);
        for (int i = 0; i < wb_pkg::NUM_SOURCES; i++) begin
            offer_gpr(i, 5'(8 + i), 5'(i), 32'($random(seed)), '0);
        end
        @(negedge clk);
        for (int k = 0; k < 5; k++) begin
            src = k % wb_pkg::NUM_SOURCES;
            while (!any_gpr_ready()) @(negedge clk);
            check_hex($sformatf("gpr_ready[%0d]", src), 32'(gpr_ready[src]), 32'd1);
            @(posedge clk);
            // Source stays valid with a fresh tag
            gpr_rs_id[src] <= 5'(8 + k + wb_pkg::NUM_SOURCES);
            if (k == 4) begin
                clear_inputs();
            end
            @(negedge clk);
            check_hex("gpr_wr_valid", 32'(gpr_wr_valid), 32'd1);
            check_hex("gpr_wr_rs_id", 32'(gpr_wr_rs_id), 32'(8 + k));
        end
    endtask

    task automatic spr_pass_through();
        logic [31:0] data;
        data = $random(seed);
        @(posedge clk);
        offer_spr(5'd21, 10'h120, data);
        @(negedge clk);
        wait_spr_ready();
        @(posedge clk);
        spr_valid <= 1'b0;
        @(negedge clk);
        check_spr_write(5'd21, 10'h120, data);
        check_hex("gpr_wr_valid", 32'(gpr_wr_valid), 32'd0);
        check_hex("cr0_wr_valid", 32'(cr0_wr_valid), 32'd0);
    endtask

    task automatic spr_shared_with_gpr();
        logic [31:0] data;
        data = $random(seed);
        @(posedge clk);
        offer_gpr(1, 5'd12, 5'd30, data, '0);
        offer_spr(5'd13, 10'h3F0, 32'hC0DE_0004);
        @(negedge clk);
        wait_spr_ready();
        check_hex("gpr_ready[1]", 32'(gpr_ready[1]), 32'd1);
        @(posedge clk);
        gpr_valid[1] <= 1'b0;
        spr_valid <= 1'b0;
        @(negedge clk);
        check_gpr_write(5'd12, 5'd30, data);
        check_spr_write(5'd13, 10'h3F0, 32'hC0DE_0004);
        check_hex("cr0_wr_valid", 32'(cr0_wr_valid), 32'd0);
    endtask

    task automatic spr_after_xer_gpr();
        apply_reset();
        @(posedge clk);
        offer_gpr(2, 5'd17, 5'd9, 32'h0000_0042, make_flags(1'b1, 32'h2000_0000, 1'b0, 1'b0));
        offer_spr(5'd18, 10'h100, 32'h1357_9BDF);
        @(negedge clk);
        // Turn flag starts clear, so the XER-carrying result wins first
        check_hex("gpr_ready[2]", 32'(gpr_ready[2]), 32'd1);
        check_hex("spr_ready", 32'(spr_ready), 32'd0);
        @(posedge clk);
        gpr_valid[2] <= 1'b0;
        @(negedge clk);
        check_gpr_write(5'd17, 5'd9, 32'h0000_0042);
        check_spr_write(5'd17, 10'd1, 32'h2000_0000);
        check_hex("spr_ready", 32'(spr_ready), 32'd1);
        @(posedge clk);
        spr_valid <= 1'b0;
        @(negedge clk);
        check_spr_write(5'd18, 10'h100, 32'h1357_9BDF);
        check_hex("gpr_wr_valid", 32'(gpr_wr_valid), 32'd0);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        seed = 32'h31467ecc;
        rst <= 1'b1;
        clear_inputs();
        idle_after_reset();
        single_gpr_side_writes();
        round_robin_order();
        spr_pass_through();
        spr_shared_with_gpr();
        spr_after_xer_gpr();
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog/write_back_arbiter.sv
/* Write-back arbiter top level
   Round-robin GPR arbitration with SPR sharing and XER/CR0 side writes */

`timescale 1ns/10ps

module write_back_arbiter (
    input logic clk,
    input logic rst,

    // GPR sources
    input logic gpr_valid [0:wb_pkg::NUM_SOURCES-1],
    output logic gpr_ready [0:wb_pkg::NUM_SOURCES-1],
    input logic [0:wb_pkg::RS_ID_W-1] gpr_rs_id [0:wb_pkg::NUM_SOURCES-1],
    input logic [0:wb_pkg::GPR_ADDR_W-1] gpr_addr [0:wb_pkg::NUM_SOURCES-1],
    input logic [0:wb_pkg::DATA_W-1] gpr_data [0:wb_pkg::NUM_SOURCES-1],
    input wb_pkg::cond_exception_t gpr_flags [0:wb_pkg::NUM_SOURCES-1],

    // SPR source
    input logic spr_valid,
    output logic spr_ready,
    input logic [0:wb_pkg::RS_ID_W-1] spr_rs_id,
    input logic [0:wb_pkg::SPR_ADDR_W-1] spr_addr,
    input logic [0:wb_pkg::DATA_W-1] spr_data,

    // GPR write port
    output logic gpr_wr_valid,
    output logic [0:wb_pkg::RS_ID_W-1] gpr_wr_rs_id,
    output logic [0:wb_pkg::GPR_ADDR_W-1] gpr_wr_addr,
    output logic [0:wb_pkg::DATA_W-1] gpr_wr_data,

    // SPR write port
    output logic spr_wr_valid,
    output logic [0:wb_pkg::RS_ID_W-1] spr_wr_rs_id,
    output logic [0:wb_pkg::SPR_ADDR_W-1] spr_wr_addr,
    output logic [0:wb_pkg::DATA_W-1] spr_wr_data,

    // CR0 write port
    output logic cr0_wr_valid,
    output logic [0:wb_pkg::RS_ID_W-1] cr0_wr_rs_id,
    output wb_pkg::cr_field_t cr0_wr_value
);

    logic [0:wb_pkg::SRC_IDX_W-1] pointer;
    wb_pkg::grant_e grant;
    logic [0:wb_pkg::SRC_IDX_W-1] grant_idx;
    logic spr_grant;

    wb_candidate_if cand ();

    wb_candidate_search i_wb_candidate_search (
        .gpr_valid (gpr_valid),
        .gpr_flags (gpr_flags),
        .pointer   (pointer),
        .cand      (cand.search)
    );

    wb_grant_select i_wb_grant_select (
        .clk       (clk),
        .rst       (rst),
        .spr_valid (spr_valid),
        .cand      (cand.grant),
        .pointer   (pointer),
        .grant     (grant),
        .grant_idx (grant_idx),
        .spr_grant (spr_grant)
    );

    wb_result_format i_wb_result_format (
        .clk          (clk),
        .rst          (rst),
        .gpr_valid    (gpr_valid),
        .gpr_rs_id    (gpr_rs_id),
        .gpr_addr     (gpr_addr),
        .gpr_data     (gpr_data),
        .gpr_flags    (gpr_flags),
        .gpr_ready    (gpr_ready),
        .spr_rs_id    (spr_rs_id),
        .spr_addr     (spr_addr),
        .spr_data     (spr_data),
        .spr_ready    (spr_ready),
        .grant        (grant),
        .grant_idx    (grant_idx),
        .spr_grant    (spr_grant),
        .gpr_wr_valid (gpr_wr_valid),
        .gpr_wr_rs_id (gpr_wr_rs_id),
        .gpr_wr_addr  (gpr_wr_addr),
        .gpr_wr_data  (gpr_wr_data),
        .spr_wr_valid (spr_wr_valid),
        .spr_wr_rs_id (spr_wr_rs_id),
        .spr_wr_addr  (spr_wr_addr),
        .spr_wr_data  (spr_wr_data),
        .cr0_wr_valid (cr0_wr_valid),
        .cr0_wr_rs_id (cr0_wr_rs_id),
        .cr0_wr_value (cr0_wr_value)
    );

endmodule

// File: verilog/wb_result_format.sv
/* Write-back result stage
   Drives the input readies, forms the XER and CR0 side writes, registers all write ports */

`timescale 1ns/10ps

module wb_result_format (
    input logic clk,
    input logic rst,

    // GPR sources
    input logic gpr_valid [0:wb_pkg::NUM_SOURCES-1],
    input logic [0:wb_pkg::RS_ID_W-1] gpr_rs_id [0:wb_pkg::NUM_SOURCES-1],
    input logic [0:wb_pkg::GPR_ADDR_W-1] gpr_addr [0:wb_pkg::NUM_SOURCES-1],
    input logic [0:wb_pkg::DATA_W-1] gpr_data [0:wb_pkg::NUM_SOURCES-1],
    input wb_pkg::cond_exception_t gpr_flags [0:wb_pkg::NUM_SOURCES-1],
    output logic gpr_ready [0:wb_pkg::NUM_SOURCES-1],

    // SPR source
    input logic [0:wb_pkg::RS_ID_W-1] spr_rs_id,
    input logic [0:wb_pkg::SPR_ADDR_W-1] spr_addr,
    input logic [0:wb_pkg::DATA_W-1] spr_data,
    output logic spr_ready,

    // Grant decision
    input wb_pkg::grant_e grant,
    input logic [0:wb_pkg::SRC_IDX_W-1] grant_idx,
    input logic spr_grant,

    // Register file write ports
    output logic gpr_wr_valid,
    output logic [0:wb_pkg::RS_ID_W-1] gpr_wr_rs_id,
    output logic [0:wb_pkg::GPR_ADDR_W-1] gpr_wr_addr,
    output logic [0:wb_pkg::DATA_W-1] gpr_wr_data,
    output logic spr_wr_valid,
    output logic [0:wb_pkg::RS_ID_W-1] spr_wr_rs_id,
    output logic [0:wb_pkg::SPR_ADDR_W-1] spr_wr_addr,
    output logic [0:wb_pkg::DATA_W-1] spr_wr_data,
    output logic cr0_wr_valid,
    output logic [0:wb_pkg::RS_ID_W-1] cr0_wr_rs_id,
    output wb_pkg::cr_field_t cr0_wr_value
);

    logic gpr_sel;
    logic [wb_pkg::NUM_SOURCES-1:0] ready_vec;
    logic [wb_pkg::NUM_SOURCES-1:0] valid_vec;

    logic [0:wb_pkg::RS_ID_W-1] sel_rs_id;
    logic [0:wb_pkg::GPR_ADDR_W-1] sel_addr;
    logic [0:wb_pkg::DATA_W-1] sel_data;
    wb_pkg::cond_exception_t sel_flags;

    logic spr_wr_next;
    logic [0:wb_pkg::RS_ID_W-1] spr_rs_id_next;
    logic [0:wb_pkg::SPR_ADDR_W-1] spr_addr_next;
    logic [0:wb_pkg::DATA_W-1] spr_data_next;

    // CR0 from a signed compare of the result against zero
    function automatic wb_pkg::cr_field_t cr0_of(
        input logic [0:wb_pkg::DATA_W-1] result,
        input logic so
    );
        wb_pkg::cr_field_t field;
        field.lt = $signed(result) < 0;
        field.gt = $signed(result) > 0;
        field.eq = (result == '0);
        field.so = so;
        return field;
    endfunction

    assign gpr_sel = (grant == wb_pkg::GRANT_NEXT) || (grant == wb_pkg::GRANT_NO_XER);

    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_SOURCES; i++) begin
            ready_vec[i] = gpr_sel && (grant_idx == wb_pkg::SRC_IDX_W'(i));
            valid_vec[i] = gpr_valid[i];
            gpr_ready[i] = ready_vec[i];
        end
    end

    assign spr_ready = spr_grant;

    // Granted GPR payload
    assign sel_rs_id = gpr_rs_id[grant_idx];
    assign sel_addr = gpr_addr[grant_idx];
    assign sel_data = gpr_data[grant_idx];
    assign sel_flags = gpr_flags[grant_idx];

    // SPR port takes either the SPR source or the XER side write, never both
    always_comb begin
        spr_wr_next = spr_grant || (gpr_sel && sel_flags.xer_valid);
        if (spr_grant) begin
            spr_rs_id_next = spr_rs_id;
            spr_addr_next = spr_addr;
            spr_data_next = spr_data;
        end else begin
            spr_rs_id_next = sel_rs_id;
            spr_addr_next = wb_pkg::XER_SPR_ADDR;
            spr_data_next = sel_flags.xer;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gpr_wr_valid <= 1'b0;
            spr_wr_valid <= 1'b0;
            cr0_wr_valid <= 1'b0;
        end else begin
            gpr_wr_valid <= gpr_sel;
            spr_wr_valid <= spr_wr_next;
            cr0_wr_valid <= gpr_sel && sel_flags.cr0_valid;
        end
    end

    always_ff @(posedge clk) begin
        gpr_wr_rs_id <= sel_rs_id;
        gpr_wr_addr <= sel_addr;
        gpr_wr_data <= sel_data;
        spr_wr_rs_id <= spr_rs_id_next;
        spr_wr_addr <= spr_addr_next;
        spr_wr_data <= spr_data_next;
        cr0_wr_rs_id <= sel_rs_id;
        cr0_wr_value <= cr0_of(sel_data, sel_flags.so);
    end

    // At most one source is accepted, and only one that is offering
    a_ready_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(ready_vec) && ((ready_vec & ~valid_vec) == '0)
    );

    // A granted result with an XER update never shares the cycle with SPR
    a_spr_xer_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(spr_grant && gpr_sel && sel_flags.xer_valid)
    );

endmodule

// File: verilog/wb_grant_select.sv
/* Write-back execute stage
   Picks the GPR and SPR grants, keeps the round-robin pointer and SPR turn flag */

`timescale 1ns/10ps

module wb_grant_select (
    input logic clk,
    input logic rst,
    input logic spr_valid,
    wb_candidate_if.grant cand,
    output logic [0:wb_pkg::SRC_IDX_W-1] pointer,
    output wb_pkg::grant_e grant,
    output logic [0:wb_pkg::SRC_IDX_W-1] grant_idx,
    output logic spr_grant
);

    logic spr_turn;
    logic spr_turn_next;
    logic gpr_granted;

    // Grant decision
    always_comb begin
        grant = wb_pkg::GRANT_NONE;
        spr_grant = 1'b0;
        spr_turn_next = spr_turn;

        if (!spr_valid) begin
            if (cand.next_found) begin
                grant = wb_pkg::GRANT_NEXT;
            end
        end else if (spr_turn) begin
            // SPR has its turn, a non-XER result may ride along
            spr_grant = 1'b1;
            grant = cand.no_xer_found ? wb_pkg::GRANT_NO_XER : wb_pkg::GRANT_SPR_ONLY;
            spr_turn_next = 1'b0;
        end else begin
            if (cand.no_xer_found) begin
                grant = wb_pkg::GRANT_NO_XER;
                spr_grant = 1'b1;
            end else if (cand.next_found) begin
                // GPR with XER update wins, SPR goes next time
                grant = wb_pkg::GRANT_NEXT;
            end else begin
                grant = wb_pkg::GRANT_SPR_ONLY;
                spr_grant = 1'b1;
            end
            spr_turn_next = 1'b1;
        end
    end

    assign grant_idx = (grant == wb_pkg::GRANT_NO_XER) ? cand.no_xer_idx : cand.next_idx;
    assign gpr_granted = (grant == wb_pkg::GRANT_NEXT) || (grant == wb_pkg::GRANT_NO_XER);

    always_ff @(posedge clk) begin
        if (rst) begin
            pointer <= '0;
            spr_turn <= 1'b0;
        end else begin
            spr_turn <= spr_turn_next;
            // Move past the source just served
            if (gpr_granted) begin
                if (grant_idx == wb_pkg::SRC_IDX_W'(wb_pkg::NUM_SOURCES - 1)) begin
                    pointer <= '0;
                end else begin
                    pointer <= grant_idx + wb_pkg::SRC_IDX_W'(1);
                end
            end
        end
    end

    // SPR is never held off for two cycles in a row
    a_spr_no_starve: assert property (
        @(posedge clk) disable iff (rst)
        (spr_valid && !spr_grant) |=> (!spr_valid || spr_grant)
    );

endmodule

// File: verilog/wb_candidate_search.sv
/* Write-back decode stage
   Rotating priority search over the GPR sources, starting at the pointer */

`timescale 1ns/10ps

module wb_candidate_search (
    input logic gpr_valid [0:wb_pkg::NUM_SOURCES-1],
    input wb_pkg::cond_exception_t gpr_flags [0:wb_pkg::NUM_SOURCES-1],
    input logic [0:wb_pkg::SRC_IDX_W-1] pointer,
    wb_candidate_if.search cand
);

    logic [wb_pkg::NUM_SOURCES-1:0] elig_all;
    logic [wb_pkg::NUM_SOURCES-1:0] elig_no_xer;

    // Returns {found, index} of the first requester at or above start, wrapping
    function automatic logic [wb_pkg::SRC_IDX_W:0] rotate_search(
        input logic [wb_pkg::NUM_SOURCES-1:0] req,
        input logic [0:wb_pkg::SRC_IDX_W-1] start
    );
        logic found;
        logic [wb_pkg::SRC_IDX_W-1:0] idx;
        int unsigned slot;
        found = 1'b0;
        idx = start;
        for (int i = 0; i < wb_pkg::NUM_SOURCES; i++) begin
            slot = (int'(start) + i) % wb_pkg::NUM_SOURCES;
            if (req[slot] && !found) begin
                idx = wb_pkg::SRC_IDX_W'(slot);
                found = 1'b1;
            end
        end
        return {found, idx};
    endfunction

    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_SOURCES; i++) begin
            elig_all[i] = gpr_valid[i];
            // Results that can share a cycle with the SPR source
            elig_no_xer[i] = gpr_valid[i] && !gpr_flags[i].xer_valid;
        end
    end

    always_comb begin
        {cand.next_found, cand.next_idx} = rotate_search(elig_all, pointer);
        {cand.no_xer_found, cand.no_xer_idx} = rotate_search(elig_no_xer, pointer);
    end

endmodule

// File: verilog/wb_candidate_if.sv
/* Round-robin candidate bundle
   Carries the two search results from the decode stage to the grant logic */

`timescale 1ns/10ps

interface wb_candidate_if;

    // First valid source at or after the pointer
    logic [0:wb_pkg::SRC_IDX_W-1] next_idx;
    logic next_found;

    // First valid source without an XER update
    logic [0:wb_pkg::SRC_IDX_W-1] no_xer_idx;
    logic no_xer_found;

    modport search (
        output next_idx,
        output next_found,
        output no_xer_idx,
        output no_xer_found
    );

    modport grant (
        input next_idx,
        input next_found,
        input no_xer_idx,
        input no_xer_found
    );

endinterface

// File: verilog/wb_pkg.sv
/* Write-back arbiter shared definitions
   Widths, register addresses and types used by every stage */

package wb_pkg;

    // Number of GPR result sources and the width of their index
    localparam int NUM_SOURCES = 4;
    localparam int SRC_IDX_W = 2;

    // Tag and register address widths
    localparam int RS_ID_W = 5;
    localparam int GPR_ADDR_W = 5;
    localparam int SPR_ADDR_W = 10;

    // Result width
    localparam int DATA_W = 32;

    // XER lives at SPR address 1
    localparam logic [0:SPR_ADDR_W-1] XER_SPR_ADDR = 10'd1;

    // Side updates that travel with a GPR result
    typedef struct packed {
        logic xer_valid;
        logic [0:DATA_W-1] xer;
        logic cr0_valid;
        logic so;
    } cond_exception_t;

    // One condition register field
    typedef struct packed {
        logic lt;
        logic gt;
        logic eq;
        logic so;
    } cr_field_t;

    // Which GPR candidate wins this cycle
    // GRANT_SPR_ONLY means SPR alone, no GPR result
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_NEXT,
        GRANT_NO_XER,
        GRANT_SPR_ONLY
    } grant_e;

endpackage
